// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_decode_pkg::*; (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   in_valid,
    output logic                  in_ready,
    input  wire [inst_w-1:0]      inst,
    output logic                  out_valid,
    input  wire                   out_ready,
    output logic [reg_addr_w-1:0] rs1_addr,
    output logic [reg_addr_w-1:0] rs2_addr,
    output logic [reg_addr_w-1:0] rd_addr,
    output logic                  reg_wen,
    output alu_op_t               alu_op,
    output alu_src_t              alu_src,
    output logic [xlen-1:0]       imm,
    output logic                  branch,
    output logic                  jump,
    output logic                  jalr,
    output logic                  mem_read,
    output logic                  mem_write,
    output mem_size_t             mem_size,
    output logic                  mem_unsigned,
    output logic                  ebreak,
    output logic                  illegal
);

    logic              mid_valid;
    logic              mid_ready;
    logic [inst_w-1:0] mid_inst;
    imm_fmt_t          imm_fmt;
    ctrl_word_t        ctrl_in;
    ctrl_word_t        ctrl_out;

    skid_buffer #(.payload_t(logic [inst_w-1:0])) in_buf (
        .clk        (clk),
        .arst_n     (arst_n),
        .up_valid   (in_valid),
        .up_ready   (in_ready),
        .up_data    (inst),
        .down_valid (mid_valid),
        .down_ready (mid_ready),
        .down_data  (mid_inst)
    );

    inst_decode u_inst_decode (
        .inst         (mid_inst),
        .rs1_addr     (ctrl_in.rs1_addr),
        .rs2_addr     (ctrl_in.rs2_addr),
        .rd_addr      (ctrl_in.rd_addr),
        .reg_wen      (ctrl_in.reg_wen),
        .alu_op       (ctrl_in.alu_op),
        .alu_src      (ctrl_in.alu_src),
        .imm_fmt      (imm_fmt),
        .branch       (ctrl_in.branch),
        .jump         (ctrl_in.jump),
        .jalr         (ctrl_in.jalr),
        .mem_read     (ctrl_in.mem_read),
        .mem_write    (ctrl_in.mem_write),
        .mem_size     (ctrl_in.mem_size),
        .mem_unsigned (ctrl_in.mem_unsigned),
        .ebreak       (ctrl_in.ebreak),
        .illegal      (ctrl_in.illegal)
    );

    imm_gen u_imm_gen (
        .inst    (mid_inst),
        .imm_fmt (imm_fmt),
        .imm     (ctrl_in.imm)
    );

    skid_buffer #(.payload_t(ctrl_word_t)) out_buf (
        .clk        (clk),
        .arst_n     (arst_n),
        .up_valid   (mid_valid),
        .up_ready   (mid_ready),
        .up_data    (ctrl_in),
        .down_valid (out_valid),
        .down_ready (out_ready),
        .down_data  (ctrl_out)
    );

    // unpack to loose ports
    assign rs1_addr     = ctrl_out.rs1_addr;
    assign rs2_addr     = ctrl_out.rs2_addr;
    assign rd_addr      = ctrl_out.rd_addr;
    assign reg_wen      = ctrl_out.reg_wen;
    assign alu_op       = ctrl_out.alu_op;
    assign alu_src      = ctrl_out.alu_src;
    assign imm          = ctrl_out.imm;
    assign branch       = ctrl_out.branch;
    assign jump         = ctrl_out.jump;
    assign jalr         = ctrl_out.jalr;
    assign mem_read     = ctrl_out.mem_read;
    assign mem_write    = ctrl_out.mem_write;
    assign mem_size     = ctrl_out.mem_size;
    assign mem_unsigned = ctrl_out.mem_unsigned;
    assign ebreak       = ctrl_out.ebreak;
    assign illegal      = ctrl_out.illegal;

endmodule

`default_nettype wire

// ==== rtl/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen import rv_decode_pkg::*; (
    input  wire [inst_w-1:0] inst,
    input  imm_fmt_t         imm_fmt,
    output logic [xlen-1:0]  imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_fmt)
            imm_i: begin
                imm = {{(xlen-12){sign}}, inst[31:20]};
            end
            imm_s: begin
                imm = {{(xlen-12){sign}}, inst[31:25], inst[11:7]};
            end
            imm_b: begin
                imm = {{(xlen-13){sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            imm_u: begin
                imm = {{(xlen-32){sign}}, inst[31:12], 12'b0};
            end
            imm_j: begin
                imm = {{(xlen-21){sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            imm_shamt: begin
                imm = {{(xlen-6){1'b0}}, inst[25:20]}; // 6-bit shift amount
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decode import rv_decode_pkg::*; (
    input  wire [inst_w-1:0]      inst,
    output logic [reg_addr_w-1:0] rs1_addr,
    output logic [reg_addr_w-1:0] rs2_addr,
    output logic [reg_addr_w-1:0] rd_addr,
    output logic                  reg_wen,
    output alu_op_t               alu_op,
    output alu_src_t              alu_src,
    output imm_fmt_t              imm_fmt,
    output logic                  branch,
    output logic                  jump,
    output logic                  jalr,
    output logic                  mem_read,
    output logic                  mem_write,
    output mem_size_t             mem_size,
    output logic                  mem_unsigned,
    output logic                  ebreak,
    output logic                  illegal
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        rs1_addr     = '0;
        rs2_addr     = '0;
        rd_addr      = '0;
        reg_wen      = 1'b0;
        alu_op       = alu_add;
        alu_src      = src_reg;
        imm_fmt      = imm_none;
        branch       = 1'b0;
        jump         = 1'b0;
        jalr         = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        mem_size     = size_byte;
        mem_unsigned = 1'b0;
        ebreak       = 1'b0;
        illegal      = 1'b0;
        case (opcode)
            opc_op: begin
                case (funct3)
                    f3_add: begin
                        if (funct7 == funct7_base) begin
                            alu_op = alu_add;
                        end else if (funct7 == funct7_alt) begin
                            alu_op = alu_sub;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                    f3_and:  alu_op = alu_and;
                    f3_or:   alu_op = alu_or;
                    f3_slt:  alu_op = alu_slt;
                    f3_sltu: alu_op = alu_sltu;
                    default: illegal = 1'b1;
                endcase
                if (funct3 != f3_add && funct7 != funct7_base) begin
                    illegal = 1'b1;
                    alu_op  = alu_add; // back to default
                end
                if (!illegal) begin
                    rs1_addr = rs1;
                    rs2_addr = rs2;
                    rd_addr  = rd;
                    reg_wen  = 1'b1;
                end
            end
            opc_op_imm: begin
                case (funct3)
                    f3_add:  alu_op = alu_add;
                    f3_sltu: alu_op = alu_sltu;
                    f3_xor:  alu_op = alu_xor;
                    f3_and:  alu_op = alu_and;
                    f3_sll: begin
                        if (funct7[6:1] == funct7_base[6:1]) begin // bit 25 is shamt[5]
                            alu_op = alu_sll;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                    f3_sr: begin
                        if (funct7 == funct7_alt) begin
                            alu_op = alu_sra;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                    default: illegal = 1'b1;
                endcase
                if (!illegal) begin
                    rs1_addr = rs1;
                    rd_addr  = rd;
                    reg_wen  = 1'b1;
                    alu_src  = src_imm;
                    imm_fmt  = (funct3 == f3_sll || funct3 == f3_sr) ? imm_shamt : imm_i;
                end
            end
            opc_load: begin
                case (funct3)
                    f3_mem_w:  mem_size = size_word;
                    f3_mem_d:  mem_size = size_dword;
                    f3_mem_h:  mem_size = size_half;
                    f3_mem_bu: begin
                        mem_size     = size_byte;
                        mem_unsigned = 1'b1;
                    end
                    f3_mem_hu: begin
                        mem_size     = size_half;
                        mem_unsigned = 1'b1;
                    end
                    default: illegal = 1'b1; // lb, lwu not supported
                endcase
                if (!illegal) begin
                    rs1_addr = rs1;
                    rd_addr  = rd;
                    reg_wen  = 1'b1;
                    alu_src  = src_imm;
                    imm_fmt  = imm_i;
                    mem_read = 1'b1;
                end
            end
            opc_store: begin
                case (funct3)
                    f3_mem_b: mem_size = size_byte;
                    f3_mem_h: mem_size = size_half;
                    f3_mem_w: mem_size = size_word;
                    f3_mem_d: mem_size = size_dword;
                    default:  illegal = 1'b1;
                endcase
                if (!illegal) begin
                    rs1_addr  = rs1;
                    rs2_addr  = rs2;
                    alu_src   = src_imm;
                    imm_fmt   = imm_s;
                    mem_write = 1'b1;
                end
            end
            opc_branch: begin
                case (funct3)
                    f3_beq:  alu_op = alu_beq;
                    f3_bne:  alu_op = alu_bne;
                    f3_blt:  alu_op = alu_blt;
                    f3_bge:  alu_op = alu_bge;
                    f3_bltu: alu_op = alu_bltu;
                    f3_bgeu: alu_op = alu_bgeu;
                    default: illegal = 1'b1;
                endcase
                if (!illegal) begin
                    rs1_addr = rs1;
                    rs2_addr = rs2;
                    imm_fmt  = imm_b;
                    branch   = 1'b1;
                end
            end
            opc_jal: begin
                rd_addr = rd;
                reg_wen = 1'b1;
                jump    = 1'b1;
                alu_src = src_four_pc; // rd gets pc + 4
                imm_fmt = imm_j;
            end
            opc_jalr: begin
                if (funct3 == f3_add) begin
                    rs1_addr = rs1;
                    rd_addr  = rd;
                    reg_wen  = 1'b1;
                    jump     = 1'b1;
                    jalr     = 1'b1;
                    alu_src  = src_four_pc;
                    imm_fmt  = imm_i;
                end else begin
                    illegal = 1'b1;
                end
            end
            opc_lui: begin
                rd_addr = rd;
                reg_wen = 1'b1;
                alu_src = src_imm; // x0 + imm
                imm_fmt = imm_u;
            end
            opc_auipc: begin
                rd_addr = rd;
                reg_wen = 1'b1;
                alu_src = src_imm_pc;
                imm_fmt = imm_u;
            end
            opc_system: begin
                if (inst == ebreak_word) begin
                    ebreak = 1'b1;
                end else begin
                    illegal = 1'b1; // ecall, csr ops
                end
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

    localparam int xlen       = 64;
    localparam int inst_w     = 32;
    localparam int reg_addr_w = 5;

    // major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_system = 7'b1110011;

    localparam logic [inst_w-1:0] ebreak_word = 32'h0010_0073;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000; // sub, srai

    // alu funct3
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // load/store funct3
    localparam logic [2:0] f3_mem_b  = 3'b000;
    localparam logic [2:0] f3_mem_h  = 3'b001;
    localparam logic [2:0] f3_mem_w  = 3'b010;
    localparam logic [2:0] f3_mem_d  = 3'b011;
    localparam logic [2:0] f3_mem_bu = 3'b100;
    localparam logic [2:0] f3_mem_hu = 3'b101;

    // branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sltu, alu_sll,
        alu_srl, alu_sra, alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
    } alu_op_t;

    typedef enum logic [1:0] {src_reg, src_imm, src_imm_pc, src_four_pc} alu_src_t;

    typedef enum logic [2:0] {
        imm_none, imm_i, imm_s, imm_b, imm_u, imm_j, imm_shamt
    } imm_fmt_t;

    typedef enum logic [1:0] {size_byte, size_half, size_word, size_dword} mem_size_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rs1_addr;
        logic [reg_addr_w-1:0] rs2_addr;
        logic [reg_addr_w-1:0] rd_addr;
        logic                  reg_wen;
        alu_op_t               alu_op;
        alu_src_t              alu_src;
        logic [xlen-1:0]       imm;
        logic                  branch;
        logic                  jump;
        logic                  jalr;
        logic                  mem_read;
        logic                  mem_write;
        mem_size_t             mem_size;
        logic                  mem_unsigned;
        logic                  ebreak;
        logic                  illegal;
    } ctrl_word_t;

endpackage

`default_nettype wire

// ==== rtl/skid_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module skid_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  wire      clk,
    input  wire      arst_n,
    input  wire      up_valid,
    output logic     up_ready,
    input  payload_t up_data,
    output logic     down_valid,
    input  wire      down_ready,
    output payload_t down_data
);

    logic     main_valid;
    payload_t main_data;
    payload_t spill_data; // occupied while up_ready is low

    assign down_valid = main_valid;
    assign down_data  = main_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            main_valid <= 1'b0;
            up_ready   <= 1'b1;
        end else if (!up_ready) begin
            // two entries held, main stays valid
            if (down_ready) begin
                up_ready <= 1'b1;
            end
        end else if (up_valid) begin
            if (main_valid && !down_ready) begin
                up_ready <= 1'b0; // word goes to spill
            end else begin
                main_valid <= 1'b1;
            end
        end else if (down_ready) begin
            main_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!up_ready) begin
            if (down_ready) begin
                main_data <= spill_data; // refill from spill
            end
        end else if (up_valid) begin
            if (main_valid && !down_ready) begin
                spill_data <= up_data;
            end else begin
                main_data <= up_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_decode_stage \
    -Mdir obj_dir -o tb_decode_stage

sim_out=$(./obj_dir/tb_decode_stage)
echo "$sim_out"
echo "$sim_out" | grep -qx "TEST OK"

// ==== tests/decode_vectors.txt ====
// columns: inst, imm (64 bit), rs1|rs2|rd (two digits each), control nibbles
// control: reg_wen alu_op alu_src branch jump jalr mem_read mem_write size unsigned ebreak illegal
002081b3 0000000000000000 010203 100000000000 // add x3, x1, x2
407302b3 0000000000000000 060705 110000000000 // sub x5, x6, x7
00c5f533 0000000000000000 0b0c0a 120000000000 // and x10, x11, x12
003160b3 0000000000000000 020301 130000000000 // or x1, x2, x3
0062a233 0000000000000000 050604 150000000000 // slt x4, x5, x6
01df3fb3 0000000000000000 1e1d1f 160000000000 // sltu x31, x30, x29
fff10093 ffffffffffffffff 020001 101000000000 // addi x1, x2, -1
0643b313 0000000000000064 070006 161000000000 // sltiu x6, x7, 100
8004c413 fffffffffffff800 090008 141000000000 // xori x8, x9, -2048
0f057513 00000000000000f0 0a000a 121000000000 // andi x10, x10, 0xf0
03f61593 000000000000003f 0c000b 171000000000 // slli x11, x12, 63
40575693 0000000000000005 0e000d 191000000000 // srai x13, x14, 5
00812083 0000000000000008 020001 101000102000 // lw x1, 8(x2)
ff023183 fffffffffffffff0 040003 101000103000 // ld x3, -16(x4)
00034283 0000000000000000 060005 101000100100 // lbu x5, 0(x6)
00241383 0000000000000002 080007 101000101000 // lh x7, 2(x8)
7fe55483 00000000000007fe 0a0009 101000101100 // lhu x9, 0x7fe(x10)
002080a3 0000000000000001 010200 001000010000 // sb x2, 1(x1)
fe321f23 fffffffffffffffe 040300 001000011000 // sh x3, -2(x4)
06532223 0000000000000064 060500 001000012000 // sw x5, 100(x6)
80743023 fffffffffffff800 080700 001000013000 // sd x7, -2048(x8)
00208863 0000000000000010 010200 0a0100000000 // beq x1, x2, 16
fe419ce3 fffffffffffffff8 030400 0b0100000000 // bne x3, x4, -8
0062c0e3 0000000000000800 050600 0c0100000000 // blt x5, x6, 2048
8083d063 fffffffffffff000 070800 0d0100000000 // bge x7, x8, -4096
00a4e263 0000000000000004 090a00 0e0100000000 // bltu x9, x10, 4
06c5ff63 000000000000007e 0b0c00 0f0100000000 // bgeu x11, x12, 126
001000ef 0000000000000800 000001 103010000000 // jal x1, 2048
ffdff06f fffffffffffffffc 000000 103010000000 // jal x0, -4
004280e7 0000000000000004 050001 103011000000 // jalr x1, 4(x5)
80000537 ffffffff80000000 00000a 101000000000 // lui x10, 0x80000
12345597 0000000012345000 00000b 102000000000 // auipc x11, 0x12345
00100073 0000000000000000 000000 000000000010 // ebreak
00000073 0000000000000000 000000 000000000001 // ecall
022081b3 0000000000000000 000000 000000000001 // mul
00315093 0000000000000000 000000 000000000001 // srli
00010083 0000000000000000 000000 000000000001 // lb
0020a063 0000000000000000 000000 000000000001 // branch funct3 010
004290e7 0000000000000000 000000 000000000001 // jalr funct3 001

// ==== tests/tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage import rv_decode_pkg::*; ();

    localparam int num_vectors      = 39;
    localparam int words_per_vector = 4; // inst, imm, regs, ctrl
    localparam int timeout_cycles   = num_vectors * 20 + 100;

    logic                  clk;
    logic                  arst_n;
    logic                  in_valid;
    logic                  in_ready;
    logic [inst_w-1:0]     inst;
    logic                  out_valid;
    logic                  out_ready;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [reg_addr_w-1:0] rd_addr;
    logic                  reg_wen;
    alu_op_t               alu_op;
    alu_src_t              alu_src;
    logic [xlen-1:0]       imm;
    logic                  branch;
    logic                  jump;
    logic                  jalr;
    logic                  mem_read;
    logic                  mem_write;
    mem_size_t             mem_size;
    logic                  mem_unsigned;
    logic                  ebreak;
    logic                  illegal;

    logic [63:0] vectors [0:num_vectors*words_per_vector-1];
    int          error_count = 0;
    int          out_count = 0;

    decode_stage UUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .inst         (inst),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rd_addr      (rd_addr),
        .reg_wen      (reg_wen),
        .alu_op       (alu_op),
        .alu_src      (alu_src),
        .imm          (imm),
        .branch       (branch),
        .jump         (jump),
        .jalr         (jalr),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_size     (mem_size),
        .mem_unsigned (mem_unsigned),
        .ebreak       (ebreak),
        .illegal      (illegal)
    );

    task automatic check_field(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("MISMATCH at %0t: %s got %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic compare_decoded(input int idx);
        logic [63:0] regs;
        logic [63:0] ctrl;
        string       tag;
        regs = vectors[idx*words_per_vector+2];
        ctrl = vectors[idx*words_per_vector+3];
        tag  = $sformatf("vector %0d (%h)", idx, vectors[idx*words_per_vector][31:0]);
        check_field({tag, " rs1_addr"}, 64'(rs1_addr), 64'(regs[23:16]));
        check_field({tag, " rs2_addr"}, 64'(rs2_addr), 64'(regs[15:8]));
        check_field({tag, " rd_addr"}, 64'(rd_addr), 64'(regs[7:0]));
        check_field({tag, " imm"}, imm, vectors[idx*words_per_vector+1]);
        check_field({tag, " reg_wen"}, 64'(reg_wen), 64'(ctrl[47:44]));
        check_field({tag, " alu_op"}, 64'(alu_op), 64'(ctrl[43:40]));
        check_field({tag, " alu_src"}, 64'(alu_src), 64'(ctrl[39:36]));
        check_field({tag, " branch"}, 64'(branch), 64'(ctrl[35:32]));
        check_field({tag, " jump"}, 64'(jump), 64'(ctrl[31:28]));
        check_field({tag, " jalr"}, 64'(jalr), 64'(ctrl[27:24]));
        check_field({tag, " mem_read"}, 64'(mem_read), 64'(ctrl[23:20]));
        check_field({tag, " mem_write"}, 64'(mem_write), 64'(ctrl[19:16]));
        check_field({tag, " mem_size"}, 64'(mem_size), 64'(ctrl[15:12]));
        check_field({tag, " mem_unsigned"}, 64'(mem_unsigned), 64'(ctrl[11:8]));
        check_field({tag, " ebreak"}, 64'(ebreak), 64'(ctrl[7:4]));
        check_field({tag, " illegal"}, 64'(illegal), 64'(ctrl[3:0]));
    endtask

    // one word per transfer, random idle gaps in between
    task automatic send_vectors();
        int i;
        for (i = 0; i < num_vectors; i++) begin
            while ($urandom % 4 == 0) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            in_valid <= 1'b1;
            inst     <= vectors[i*words_per_vector][inst_w-1:0];
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic finish_run();
        $display("decoded %0d of %0d vectors, %0d errors", out_count, num_vectors, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin
        out_ready <= 1'b0;
        forever begin
            @(posedge clk);
            out_ready <= ($urandom % 3) != 0; // ready about two thirds of the time
        end
    end

    // outputs sampled at the edge, before any update lands
    always @(posedge clk) begin
        if (arst_n && out_valid && out_ready) begin
            if (out_count < num_vectors) begin
                compare_decoded(out_count);
            end else begin
                error_count++;
                $display("extra decoded word left the DUT at %0t", $time);
            end
            out_count++;
        end
    end

    initial begin
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        error_count++;
        $display("timeout after %0d cycles, only %0d of %0d decoded words came out",
                 cycle_count, out_count, num_vectors);
        finish_run();
    end

    initial begin
        int k;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'he16f97c5));
        arst_n   <= 1'b0;
        in_valid <= 1'b0;
        inst     <= '0;
        for (k = 0; k < num_vectors * words_per_vector; k++) begin
            vectors[k] = {16'hffff, 48'(k)}; // overwritten by the file
        end
        $readmemh("tests/decode_vectors.txt", vectors);
        if (vectors[num_vectors*words_per_vector-1][63:48] != 16'h0) begin
            error_count++;
            $display("vector file tests/decode_vectors.txt is missing or shorter than expected");
        end
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_field("in_ready after reset", 64'(in_ready), 64'd1);
        check_field("out_valid after reset", 64'(out_valid), 64'd0);
        send_vectors();
        wait (out_count >= num_vectors);
        repeat (16) @(posedge clk); // room for a stray extra word
        finish_run();
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/rv_decode_pkg.sv
rtl/skid_buffer.sv
rtl/imm_gen.sv
rtl/inst_decode.sv
rtl/decode_stage.sv
tests/tb_decode_stage.sv
